// File: dv/hist_tb.sv
// Testbench hist_tb with a stimulus table, a reference histogram model, per-cycle checks and a timeout
`timescale 1ns/1ps
`include "hist_settings.svh"

module hist_tb;

	import hist_pkg::*;

	// Table actions
	typedef enum int {
		ACT_SAMPLE,
		ACT_READ,
		ACT_WRITE,
		ACT_PAIR,
		ACT_SAMPLE_READ,
		ACT_SAMPLE_WRITE
	} act_e;

	localparam int TBL_MAX = 160;
	localparam int NBINS = 1 << `HIST_AW;
	localparam int NRAND = 20;
	localparam logic [`HIST_DW-1:0] COUNT_MAX = {`HIST_DW{1'b1}};

	logic clk;
	logic rst_n;
	logic [`HIST_AW-1:0] sample_bin;
	logic sample_valid;
	logic host_strobe;
	host_op_e host_op;
	logic [`HIST_AW-1:0] host_addr;
	logic [`HIST_DW-1:0] host_wdata;
	logic [`HIST_DW-1:0] rd_data;
	logic rd_valid;
	logic error;

	// Stimulus table
	// bin_a is the host bin, bin_b the sample bin or the second bin of a pair
	act_e tbl_act [TBL_MAX];
	logic [`HIST_AW-1:0] tbl_bin_a [TBL_MAX];
	logic [`HIST_AW-1:0] tbl_bin_b [TBL_MAX];
	logic [`HIST_DW-1:0] tbl_wdata [TBL_MAX];
	logic [`HIST_DW-1:0] tbl_exp_rd [TBL_MAX];
	logic tbl_exp_err [TBL_MAX];
	int n_entries;

	// Reference histogram updated while the table is built
	logic [`HIST_DW-1:0] ref_hist [NBINS];
	logic [`HIST_AW-1:0] rand_bins [NRAND];

	int err_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	int cycles = 0;
	int cycle_limit = 16 + 8 * TBL_MAX + 50;
	int unsigned seed;

	hist_top dut (
		.clk(clk),
		.rst_n(rst_n),
		.sample_bin(sample_bin),
		.sample_valid(sample_valid),
		.host_strobe(host_strobe),
		.host_op(host_op),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.rd_data(rd_data),
		.rd_valid(rd_valid),
		.error(error)
	);

	// 20 ns clock
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Run length guard
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Count plus one held at the top value
	function automatic logic [`HIST_DW-1:0] sat_inc(input logic [`HIST_DW-1:0] v);
		return (v == COUNT_MAX) ? v : v + 1'b1;
	endfunction

	function automatic string act_name(input act_e act);
		case (act)
			ACT_SAMPLE: return "sample";
			ACT_READ: return "read";
			ACT_WRITE: return "write";
			ACT_PAIR: return "write pair";
			ACT_SAMPLE_READ: return "sample+read";
			default: return "sample+write";
		endcase
	endfunction

	// Append one entry and step the model
	// Host read sees the model from before a concurrent sample
	task automatic add_entry(input act_e act, input int a, input int b,
			input logic [`HIST_DW-1:0] wdata, input logic exp_err);
		tbl_act[n_entries] = act;
		tbl_bin_a[n_entries] = a;
		tbl_bin_b[n_entries] = b;
		tbl_wdata[n_entries] = wdata;
		tbl_exp_err[n_entries] = exp_err;
		tbl_exp_rd[n_entries] = ref_hist[a];
		if (act == ACT_WRITE || act == ACT_SAMPLE_WRITE || act == ACT_PAIR) begin
			ref_hist[a] = wdata;
		end
		if (act == ACT_PAIR) begin
			ref_hist[b] = wdata;
		end
		if (act == ACT_SAMPLE || act == ACT_SAMPLE_READ || act == ACT_SAMPLE_WRITE) begin
			ref_hist[b] = sat_inc(ref_hist[b]);
		end
		n_entries++;
	endtask

	task automatic build_table();
		int i;
		n_entries = 0;
		// Clear every bin from the host side
		for (i = 0; i < NBINS; i++) begin
			add_entry(ACT_WRITE, i, i, '0, 1'b0);
		end
		// Write then read back
		add_entry(ACT_WRITE, 5, 5, 8'ha5, 1'b0);
		add_entry(ACT_READ, 5, 5, '0, 1'b0);
		// Saturation from 254
		add_entry(ACT_WRITE, 9, 9, 8'hfe, 1'b0);
		for (i = 0; i < 3; i++) begin
			add_entry(ACT_SAMPLE, 9, 9, '0, 1'b0);
		end
		add_entry(ACT_READ, 9, 9, '0, 1'b0);
		// Repeats of one bin at two cycle spacing
		for (i = 0; i < 4; i++) begin
			add_entry(ACT_SAMPLE, 12, 12, '0, 1'b0);
		end
		add_entry(ACT_READ, 12, 12, '0, 1'b0);
		// Random bins and then a read of each
		for (i = 0; i < NRAND; i++) begin
			rand_bins[i] = $urandom % NBINS;
			add_entry(ACT_SAMPLE, rand_bins[i], rand_bins[i], '0, 1'b0);
		end
		for (i = 0; i < NRAND; i++) begin
			add_entry(ACT_READ, rand_bins[i], rand_bins[i], '0, 1'b0);
		end
		// Sample and host strobed together
		add_entry(ACT_SAMPLE_READ, 12, 12, '0, 1'b0);
		add_entry(ACT_READ, 12, 12, '0, 1'b0);
		add_entry(ACT_SAMPLE_WRITE, 20, 21, 8'h3c, 1'b0);
		add_entry(ACT_READ, 20, 20, '0, 1'b0);
		add_entry(ACT_READ, 21, 21, '0, 1'b0);
		// Back-to-back host writes flag error and both still land
		add_entry(ACT_PAIR, 30, 31, 8'h77, 1'b1);
		add_entry(ACT_READ, 30, 30, '0, 1'b0);
		add_entry(ACT_READ, 31, 31, '0, 1'b0);
	endtask

	task automatic drive_idle();
		sample_valid = 1'b0;
		sample_bin = '0;
		host_strobe = 1'b0;
		host_op = HOST_READ;
		host_addr = '0;
		host_wdata = '0;
	endtask

	task automatic note_mismatch(input string name, input logic [`HIST_DW-1:0] exp,
			input logic [`HIST_DW-1:0] got);
		err_count++;
		$display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
	endtask

	// Apply one entry and check outputs mid-cycle over its window
	task automatic run_entry(input int e);
		int win;
		int k;
		int errs_before;
		logic exp_valid;
		logic exp_error;
		errs_before = err_count;
		win = (tbl_act[e] == ACT_SAMPLE) ? 2 : 6;
		for (k = 0; k < win; k++) begin
			@(posedge clk);
			#1;
			drive_idle();
			if (k == 0) begin
				if (tbl_act[e] == ACT_SAMPLE || tbl_act[e] == ACT_SAMPLE_READ ||
						tbl_act[e] == ACT_SAMPLE_WRITE) begin
					sample_valid = 1'b1;
					sample_bin = tbl_bin_b[e];
				end
				if (tbl_act[e] != ACT_SAMPLE) begin
					host_strobe = 1'b1;
					host_addr = tbl_bin_a[e];
					host_wdata = tbl_wdata[e];
					if (tbl_act[e] == ACT_READ || tbl_act[e] == ACT_SAMPLE_READ) begin
						host_op = HOST_READ;
					end else begin
						host_op = HOST_WRITE;
					end
				end
			end
			// Second write of a pair one cycle after the first
			if (k == 1 && tbl_act[e] == ACT_PAIR) begin
				host_strobe = 1'b1;
				host_op = HOST_WRITE;
				host_addr = tbl_bin_b[e];
				host_wdata = tbl_wdata[e];
			end
			@(negedge clk);
			exp_valid = (k == 3) && (tbl_act[e] == ACT_READ || tbl_act[e] == ACT_SAMPLE_READ);
			exp_error = (k == 2) && tbl_exp_err[e];
			if (rd_valid !== exp_valid) begin
				note_mismatch("rd_valid", exp_valid, rd_valid);
			end
			if (exp_valid && rd_data !== tbl_exp_rd[e]) begin
				note_mismatch("rd_data", tbl_exp_rd[e], rd_data);
			end
			if (error !== exp_error) begin
				note_mismatch("error", exp_error, error);
			end
		end
		if (err_count == errs_before) begin
			pass_count++;
			$display("entry %0d %s bin %0d/%0d pass", e, act_name(tbl_act[e]),
				tbl_bin_a[e], tbl_bin_b[e]);
		end else begin
			fail_count++;
			$display("entry %0d %s bin %0d/%0d fail", e, act_name(tbl_act[e]),
				tbl_bin_a[e], tbl_bin_b[e]);
		end
	endtask

	initial begin
		int e;
		seed = 32'h473450e9;
		void'($urandom(seed));
		rst_n = 1'b0;
		drive_idle();
		build_table();
		cycle_limit = 16 + 8 * n_entries + 50;
		// Reset for 16 cycles
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (e = 0; e < n_entries; e++) begin
			run_entry(e);
		end
		$display("entries %0d passed %0d failed %0d mismatches %0d",
			n_entries, pass_count, fail_count, err_count);
		if (err_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+hdl
hdl/hist_pkg.sv
hdl/dpram.sv
hdl/fake_dpram.sv
hdl/hist_accumulator.sv
hdl/host_access.sv
hdl/hist_top.sv
dv/hist_tb.sv

// File: hdl/dpram.sv
// Module dpram, an inferred simple dual-port RAM with one write port and one read port
`timescale 1ns/1ps
`include "hist_settings.svh"

module dpram #(
	parameter int aw = `HIST_AW,
	parameter int dw = `HIST_DW
) (
	input logic clk,
	// Write port
	input logic [aw-1:0] addra,
	input logic [dw-1:0] dina,
	input logic wena,
	// Read port, reads on every cycle
	input logic [aw-1:0] addrb,
	output logic [dw-1:0] doutb
);

	// Storage array
	// No reset, contents come from the writers
	logic [dw-1:0] mem [0:(1<<aw)-1];

	// Write on strobe
	always_ff @(posedge clk) begin
		if (wena) begin
			mem[addra] <= dina;
		end
	end

	// Registered read of addrb every cycle
	// Same-cycle write and read of one address returns the old word
	always_ff @(posedge clk) begin
		doutb <= mem[addrb];
	end

endmodule

// File: hdl/fake_dpram.sv
// Module fake_dpram with two emulated read/write ports over one dpram and the hog error output
`timescale 1ns/1ps
`include "hist_settings.svh"

module fake_dpram #(
	parameter int aw = `HIST_AW,
	parameter int dw = `HIST_DW
) (
	input logic clk,
	input logic rst_n,
	// Port 1 with one cycle read latency
	input logic [aw-1:0] addr1,
	input logic [dw-1:0] din1,
	input logic wen1,
	input logic ren1,
	output logic [dw-1:0] dout1,
	// Port 2 with two cycle read latency
	input logic [aw-1:0] addr2,
	input logic [dw-1:0] din2,
	input logic wen2,
	input logic ren2,
	output logic [dw-1:0] dout2,
	// Strobe spacing violation on either port
	output logic error
);

	// Delayed port 2 payload for replay
	logic [aw-1:0] addr2_d;
	logic [dw-1:0] din2_d;
	// Delayed strobes
	logic wen1_d;
	logic ren1_d;
	logic wen2_d;
	logic ren2_d;
	logic ren1_dd;
	logic ren2_dd;
	// RAM side signals
	logic [aw-1:0] addra;
	logic [dw-1:0] dina;
	logic wena;
	logic [aw-1:0] addrb;
	logic [dw-1:0] doutb;
	logic [dw-1:0] doutb_d;
	// Data shown outside a read return cycle
	logic [dw-1:0] filler;

	assign filler = `HIST_SIMULATE ? {dw{1'bx}} : {dw{1'b0}};

	// Port 2 payload sampled every cycle
	always_ff @(posedge clk) begin
		addr2_d <= addr2;
		din2_d <= din2;
		doutb_d <= doutb;
	end

	// Strobe history
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wen1_d <= 1'b0;
			ren1_d <= 1'b0;
			wen2_d <= 1'b0;
			ren2_d <= 1'b0;
			ren1_dd <= 1'b0;
			ren2_dd <= 1'b0;
		end else begin
			wen1_d <= wen1;
			ren1_d <= ren1;
			wen2_d <= wen2;
			ren2_d <= ren2;
			ren1_dd <= ren1_d;
			ren2_dd <= ren2_d;
		end
	end

	// Write side arbitration
	// Port 1 first, then port 2, then a port 2 write that lost last cycle
	assign addra = wen1 ? addr1 : (wen2 ? addr2 : addr2_d);
	assign dina = wen1 ? din1 : (wen2 ? din2 : din2_d);
	assign wena = wen1 | wen2 | (wen1_d & wen2_d);

	// Read side arbitration in the same order
	// Idle cycles read the delayed port 2 address, which covers the replay
	assign addrb = ren1 ? addr1 : (ren2 ? addr2 : addr2_d);

	dpram #(
		.aw(aw),
		.dw(dw)
	) mem (
		.clk(clk),
		.addra(addra),
		.dina(dina),
		.wena(wena),
		.addrb(addrb),
		.doutb(doutb)
	);

	// Port 1 read data straight from the RAM register
	assign dout1 = ren1_d ? doutb : filler;

	// Port 2 read data one cycle later
	// Bypass the extra register when port 1 pushed this read back a cycle
	assign dout2 = ren2_dd ? (ren1_dd ? doutb : doutb_d) : filler;

	// Same strobe on one port in back-to-back cycles
	assign error = (wen1 & wen1_d) | (ren1 & ren1_d) | (wen2 & wen2_d) | (ren2 & ren2_d);

	// Port 1 read returns real data in the following cycle
	a_dout1_known: assert property (@(posedge clk) disable iff (!rst_n)
		ren1 |=> !$isunknown(dout1));

endmodule

// File: hdl/hist_accumulator.sv
// Module hist_accumulator, a read-increment-write pipeline on port 1 for each sample
`timescale 1ns/1ps
`include "hist_settings.svh"

module hist_accumulator (
	input logic clk,
	input logic rst_n,
	// Incoming samples
	input logic [`HIST_AW-1:0] sample_bin,
	input logic sample_valid,
	// Port 1 of the shared RAM
	output logic [`HIST_AW-1:0] addr1,
	output logic [`HIST_DW-1:0] din1,
	output logic wen1,
	output logic ren1,
	input logic [`HIST_DW-1:0] dout1
);

	import hist_pkg::*;

	// Read stage state and its bin
	acc_state_e rd_state;
	logic [`HIST_AW-1:0] rd_bin;
	// Update stage state and its bin
	acc_state_e wr_state;
	logic [`HIST_AW-1:0] wr_bin;
	// True when the fetched count has hit the limit
	logic at_max;

	// Stage control
	// Each sample moves IDLE -> READ -> UPDATE, one stage per cycle
	// A new sample may sit in READ while the previous one is in UPDATE
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_state <= ACC_IDLE;
			wr_state <= ACC_IDLE;
		end else begin
			rd_state <= sample_valid ? ACC_READ : ACC_IDLE;
			wr_state <= (rd_state == ACC_READ) ? ACC_UPDATE : ACC_IDLE;
		end
	end

	// Bin follows its sample down the pipe
	always_ff @(posedge clk) begin
		if (sample_valid) begin
			rd_bin <= sample_bin;
		end
		wr_bin <= rd_bin;
	end

	// Strobes come straight from the stage states
	assign ren1 = (rd_state == ACC_READ);
	assign wen1 = (wr_state == ACC_UPDATE);

	// Single address on the port
	// Update has the bus when both stages want it, which only happens on bad spacing
	assign addr1 = wen1 ? wr_bin : rd_bin;

	// Old count is on dout1 during UPDATE
	assign at_max = (dout1 == HIST_COUNT_MAX);

	// Saturating increment
	assign din1 = at_max ? dout1 : dout1 + 1'b1;

	// Samples need a free cycle between them
	// Closer spacing makes the two stages collide on port 1
	a_sample_spacing: assert property (@(posedge clk) disable iff (!rst_n)
		sample_valid |=> !sample_valid);

endmodule

// File: hdl/hist_pkg.sv
// Package hist_pkg with the host opcode enum, the accumulator state enum and the count limit
`include "hist_settings.svh"

package hist_pkg;

	// Host command opcode
	// Reads return data on rd_data, writes preload or clear a bin
	typedef enum logic {
		HOST_READ = 1'b0,
		HOST_WRITE = 1'b1
	} host_op_e;

	// Accumulator pipeline stage state
	// ACC_READ fetches the old count, ACC_UPDATE writes it back
	typedef enum logic [1:0] {
		ACC_IDLE = 2'd0,
		ACC_READ = 2'd1,
		ACC_UPDATE = 2'd2
	} acc_state_e;

	// Largest count a bin can hold
	localparam logic [`HIST_DW-1:0] HIST_COUNT_MAX = {`HIST_DW{1'b1}};

endpackage

// File: hdl/hist_settings.svh
// Width macros and the idle read data filler switch for the histogram engine
`ifndef HIST_SETTINGS_SVH
`define HIST_SETTINGS_SVH

// Bin address width
// 6 bits gives 64 bins
`define HIST_AW 6

// Count and data width
// Counts saturate at 2**HIST_DW - 1
`define HIST_DW 8

// Idle read data filler
// 1 shows X on data outputs outside a read return cycle
// 0 shows zero there, as wanted for synthesis
`define HIST_SIMULATE 1

`endif

// File: hdl/hist_top.sv
// Module hist_top, the histogram engine with accumulator, emulated dual-port RAM and host access
`timescale 1ns/1ps
`include "hist_settings.svh"

module hist_top (
	input logic clk,
	input logic rst_n,
	// Sample stream
	input logic [`HIST_AW-1:0] sample_bin,
	input logic sample_valid,
	// Host commands
	input logic host_strobe,
	input hist_pkg::host_op_e host_op,
	input logic [`HIST_AW-1:0] host_addr,
	input logic [`HIST_DW-1:0] host_wdata,
	// Host read return
	output logic [`HIST_DW-1:0] rd_data,
	output logic rd_valid,
	// Strobe spacing violation
	output logic error
);

	// Port 1, accumulator side
	logic [`HIST_AW-1:0] addr1;
	logic [`HIST_DW-1:0] din1;
	logic [`HIST_DW-1:0] dout1;
	logic wen1;
	logic ren1;
	// Port 2, host side
	logic [`HIST_AW-1:0] addr2;
	logic [`HIST_DW-1:0] din2;
	logic [`HIST_DW-1:0] dout2;
	logic wen2;
	logic ren2;

	hist_accumulator acc (
		.clk(clk),
		.rst_n(rst_n),
		.sample_bin(sample_bin),
		.sample_valid(sample_valid),
		.addr1(addr1),
		.din1(din1),
		.wen1(wen1),
		.ren1(ren1),
		.dout1(dout1)
	);

	// Shared bin memory
	fake_dpram #(
		.aw(`HIST_AW),
		.dw(`HIST_DW)
	) ram (
		.clk(clk),
		.rst_n(rst_n),
		.addr1(addr1),
		.din1(din1),
		.wen1(wen1),
		.ren1(ren1),
		.dout1(dout1),
		.addr2(addr2),
		.din2(din2),
		.wen2(wen2),
		.ren2(ren2),
		.dout2(dout2),
		.error(error)
	);

	host_access host (
		.clk(clk),
		.rst_n(rst_n),
		.host_strobe(host_strobe),
		.host_op(host_op),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.addr2(addr2),
		.din2(din2),
		.wen2(wen2),
		.ren2(ren2),
		.dout2(dout2),
		.rd_data(rd_data),
		.rd_valid(rd_valid)
	);

endmodule

// File: hdl/host_access.sv
// Module host_access, host command issue on port 2 and read data return tracking
`timescale 1ns/1ps
`include "hist_settings.svh"

module host_access (
	input logic clk,
	input logic rst_n,
	// Host command
	input logic host_strobe,
	input hist_pkg::host_op_e host_op,
	input logic [`HIST_AW-1:0] host_addr,
	input logic [`HIST_DW-1:0] host_wdata,
	// Port 2 of the shared RAM
	output logic [`HIST_AW-1:0] addr2,
	output logic [`HIST_DW-1:0] din2,
	output logic wen2,
	output logic ren2,
	input logic [`HIST_DW-1:0] dout2,
	// Read return
	output logic [`HIST_DW-1:0] rd_data,
	output logic rd_valid
);

	import hist_pkg::*;

	// Read issue history
	// Bit 0 one cycle after ren2, bit 1 two cycles after
	logic [1:0] rd_track;
	logic is_read;
	logic is_write;

	assign is_read = host_strobe && (host_op == HOST_READ);
	assign is_write = host_strobe && (host_op == HOST_WRITE);

	// Address and data held from the last command
	always_ff @(posedge clk) begin
		if (host_strobe) begin
			addr2 <= host_addr;
			din2 <= host_wdata;
		end
	end

	// One port 2 pulse per command, a cycle after the strobe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ren2 <= 1'b0;
			wen2 <= 1'b0;
		end else begin
			ren2 <= is_read;
			wen2 <= is_write;
		end
	end

	// Follow each read for the two cycles of port 2 latency
	// Two reads can be in flight, one per bit
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_track <= 2'b00;
		end else begin
			rd_track <= {rd_track[0], ren2};
		end
	end

	// Valid lines up with the cycle dout2 carries the word
	assign rd_valid = rd_track[1];

	// Data from port 2, filler between returns
	assign rd_data = dout2;

endmodule
